// ==== hdl/uno_consts.svh ====
`ifndef UNO_CONSTS_SVH
`define UNO_CONSTS_SVH

// card layout is {colour, value}
`define CARD_W      6
`define COLOR_W     2
`define VALUE_W     4

`define HAND_SLOTS  16
`define SLOT_IDX_W  4   // log2 of HAND_SLOTS

`define DEAL_COUNT  7   // cards in the opening deal
`define WILD_VALUE  13  // value code shared by every wild card

`endif

// ==== hdl/uno_pkg.sv ====
`include "uno_consts.svh"

package uno_pkg;

    typedef logic [`COLOR_W-1:0] color_t;     // 0 red, 1 yellow, 2 green, 3 blue
    typedef logic [`VALUE_W-1:0] value_t;     // 0-9 numbers, 10 skip, 11 rev, 12 +2, 13 wild

    typedef struct packed {
        color_t color;
        value_t value;
    } card_t;

    typedef logic [`SLOT_IDX_W-1:0] slot_idx_t;
    typedef logic [2:0]             draw_cnt_t;  // cards still to fetch

    typedef struct packed {
        logic  played;
        card_t card;   // zero when nothing was played
    } play_result_t;

    typedef card_t [`HAND_SLOTS-1:0] hand_t;

    typedef enum logic [1:0] {
        INTAKE_IDLE,
        INTAKE_FETCH,
        INTAKE_STORE
    } intake_state_t;

    typedef enum logic [1:0] {
        SEL_IDLE,
        SEL_CHOOSE,
        SEL_DRAW,
        SEL_REPORT
    } select_state_t;

endpackage

// ==== hdl/card_intake.sv ====
`timescale 1ns/1ps
`include "uno_consts.svh"

module card_intake (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_deal,
    input  logic           i_draw_valid,
    output logic           o_draw_ready,
    output logic           o_busy,
    output logic           o_draw_req,
    input  logic           i_card_valid,
    output logic           o_card_ready,
    input  uno_pkg::card_t i_card,
    output logic           o_ins_valid,
    input  logic           i_ins_ready,
    output uno_pkg::card_t o_ins_card
);
    import uno_pkg::*;

    intake_state_t state;
    draw_cnt_t     remain;
    card_t         card_r;
    logic          card_fire;

    assign card_fire = i_card_valid && o_card_ready;

    assign o_draw_ready = (state == INTAKE_IDLE);
    assign o_busy       = (state != INTAKE_IDLE);

    // still asking the deck while a held card waits, as long as more are owed
    assign o_draw_req   = (state == INTAKE_FETCH) ||
                          ((state == INTAKE_STORE) && (remain != '0));
    assign o_card_ready = (state == INTAKE_FETCH) && i_ins_ready; // stall when hand is full

    assign o_ins_valid  = (state == INTAKE_STORE);
    assign o_ins_card   = card_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= INTAKE_IDLE;
            remain <= '0;
        end else begin
            case (state)
                INTAKE_IDLE: begin
                    if (i_draw_valid) begin // selector draw beats a deal in the same cycle
                        remain <= draw_cnt_t'(1);
                        state  <= INTAKE_FETCH;
                    end else if (i_deal) begin
                        remain <= draw_cnt_t'(`DEAL_COUNT);
                        state  <= INTAKE_FETCH;
                    end
                end
                INTAKE_FETCH: begin
                    if (card_fire) begin
                        remain <= remain - draw_cnt_t'(1);
                        state  <= INTAKE_STORE;
                    end
                end
                INTAKE_STORE: begin
                    if (i_ins_ready) begin
                        if (remain == '0) begin
                            state <= INTAKE_IDLE;
                        end else begin
                            state <= INTAKE_FETCH;
                        end
                    end
                end
                default: begin
                    state <= INTAKE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (card_fire) begin
            card_r <= i_card;
        end
    end

endmodule

// ==== hdl/hand_store.sv ====
`timescale 1ns/1ps
`include "uno_consts.svh"

module hand_store (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_ins_valid,
    output logic                   o_ins_ready,
    input  uno_pkg::card_t         i_ins_card,
    input  logic                   i_rem_valid,
    input  uno_pkg::slot_idx_t     i_rem_idx,
    output uno_pkg::hand_t         o_hand,
    output logic [`HAND_SLOTS-1:0] o_slot_used
);
    import uno_pkg::*;

    hand_t                  hand_r;
    logic [`HAND_SLOTS-1:0] used_r;
    slot_idx_t              free_idx;
    logic                   free_found;
    logic                   ins_fire;

    // lowest free slot, searched upward
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = 0; i < `HAND_SLOTS; i++) begin
            if (!used_r[i] && !free_found) begin
                free_idx   = slot_idx_t'(i);
                free_found = 1'b1;
            end
        end
    end

    assign o_ins_ready = free_found; // low only when every slot is taken
    assign ins_fire    = i_ins_valid && free_found;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            used_r <= '0;
        end else begin
            // a removed slot is used and the insert slot is free, so they never collide
            if (i_rem_valid) begin
                used_r[i_rem_idx] <= 1'b0;
            end
            if (ins_fire) begin
                used_r[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (ins_fire) begin
            hand_r[free_idx] <= i_ins_card;
        end
    end

    assign o_hand      = hand_r;
    assign o_slot_used = used_r;

endmodule

// ==== hdl/play_selector.sv ====
`timescale 1ns/1ps
`include "uno_consts.svh"

module play_selector (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_turn_valid,
    output logic                   o_turn_ready,
    input  uno_pkg::card_t         i_top_card,
    input  uno_pkg::hand_t         i_hand,
    input  logic [`HAND_SLOTS-1:0] i_slot_used,
    input  logic                   i_intake_busy,
    output logic                   o_draw_valid,
    input  logic                   i_draw_ready,
    output logic                   o_rem_valid,
    output uno_pkg::slot_idx_t     o_rem_idx,
    output logic                   o_play_valid,
    output uno_pkg::play_result_t  o_play,
    input  logic                   i_play_ready
);
    import uno_pkg::*;

    select_state_t          state;
    card_t                  top_card_r;
    play_result_t           result_r;
    logic                   play_valid_r;
    logic                   draw_sent;
    logic                   turn_fire;
    logic [`HAND_SLOTS-1:0] color_hit;
    logic [`HAND_SLOTS-1:0] value_hit;
    logic [`HAND_SLOTS-1:0] wild_hit;
    logic [`HAND_SLOTS-1:0] pick_vec;
    slot_idx_t              pick_idx;
    logic                   pick_found;

    assign o_turn_ready = (state == SEL_IDLE) && !i_intake_busy;
    assign turn_fire    = i_turn_valid && o_turn_ready;

    // per-slot match flags, wild slots only count in the last tier
    always_comb begin
        for (int i = 0; i < `HAND_SLOTS; i++) begin
            wild_hit[i]  = i_slot_used[i] && (i_hand[i].value == value_t'(`WILD_VALUE));
            color_hit[i] = i_slot_used[i] && !wild_hit[i] &&
                           (i_hand[i].color == top_card_r.color);
            value_hit[i] = i_slot_used[i] && !wild_hit[i] &&
                           (i_hand[i].value == top_card_r.value);
        end
    end

    // colour beats value beats wild
    assign pick_vec = (|color_hit) ? color_hit :
                      (|value_hit) ? value_hit : wild_hit;
    assign pick_found = |pick_vec;

    always_comb begin
        pick_idx = '0;
        for (int i = `HAND_SLOTS-1; i >= 0; i--) begin
            if (pick_vec[i]) begin
                pick_idx = slot_idx_t'(i);
            end
        end
    end

    assign o_rem_valid  = (state == SEL_CHOOSE) && pick_found;
    assign o_rem_idx    = pick_idx;
    assign o_draw_valid = (state == SEL_DRAW) && !draw_sent;
    assign o_play_valid = play_valid_r;
    assign o_play       = result_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= SEL_IDLE;
            play_valid_r <= 1'b0;
            draw_sent    <= 1'b0;
        end else begin
            case (state)
                SEL_IDLE: begin
                    if (turn_fire) begin
                        state <= SEL_CHOOSE;
                    end
                end
                SEL_CHOOSE: begin
                    if (pick_found) begin
                        state <= SEL_REPORT;
                    end else begin
                        draw_sent <= 1'b0;
                        state     <= SEL_DRAW;
                    end
                end
                SEL_DRAW: begin
                    if (!draw_sent) begin
                        if (i_draw_ready) begin
                            draw_sent <= 1'b1;
                        end
                    end else if (!i_intake_busy) begin // drawn card now sits in the hand
                        state <= SEL_REPORT;
                    end
                end
                SEL_REPORT: begin
                    if (!play_valid_r) begin
                        play_valid_r <= 1'b1;
                    end else if (i_play_ready) begin
                        play_valid_r <= 1'b0;
                        state        <= SEL_IDLE;
                    end
                end
                default: begin
                    state <= SEL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (turn_fire) begin
            top_card_r <= i_top_card;
        end
        if (state == SEL_CHOOSE) begin
            result_r.played <= pick_found;
            result_r.card   <= pick_found ? i_hand[pick_idx] : '0;
        end
    end

endmodule

// ==== hdl/uno_player.sv ====
`timescale 1ns/1ps
`include "uno_consts.svh"

module uno_player (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_deal,
    input  logic                  i_turn_valid,
    output logic                  o_turn_ready,
    input  uno_pkg::card_t        i_top_card,
    output logic                  o_draw_req,
    input  logic                  i_card_valid,
    output logic                  o_card_ready,
    input  uno_pkg::card_t        i_card,
    output logic                  o_play_valid,
    output uno_pkg::play_result_t o_play,
    input  logic                  i_play_ready
);
    import uno_pkg::*;

    logic                   draw_valid;
    logic                   draw_ready;
    logic                   intake_busy;
    logic                   ins_valid;
    logic                   ins_ready;
    card_t                  ins_card;
    logic                   rem_valid;
    slot_idx_t              rem_idx;
    hand_t                  hand;
    logic [`HAND_SLOTS-1:0] slot_used;

    card_intake intake_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_deal       (i_deal),
        .i_draw_valid (draw_valid),
        .o_draw_ready (draw_ready),
        .o_busy       (intake_busy),
        .o_draw_req   (o_draw_req),
        .i_card_valid (i_card_valid),
        .o_card_ready (o_card_ready),
        .i_card       (i_card),
        .o_ins_valid  (ins_valid),
        .i_ins_ready  (ins_ready),
        .o_ins_card   (ins_card)
    );

    hand_store hand_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ins_valid (ins_valid),
        .o_ins_ready (ins_ready),
        .i_ins_card  (ins_card),
        .i_rem_valid (rem_valid),
        .i_rem_idx   (rem_idx),
        .o_hand      (hand),
        .o_slot_used (slot_used)
    );

    play_selector selector_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_turn_valid  (i_turn_valid),
        .o_turn_ready  (o_turn_ready),
        .i_top_card    (i_top_card),
        .i_hand        (hand),
        .i_slot_used   (slot_used),
        .i_intake_busy (intake_busy),
        .o_draw_valid  (draw_valid),
        .i_draw_ready  (draw_ready),
        .o_rem_valid   (rem_valid),
        .o_rem_idx     (rem_idx),
        .o_play_valid  (o_play_valid),
        .o_play        (o_play),
        .i_play_ready  (i_play_ready)
    );

endmodule

// ==== bench/uno_player_checker.sv ====
`timescale 1ns/1ps

module uno_player_checker (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  o_turn_ready,
    input logic                  o_draw_req,
    input logic                  o_card_ready,
    input logic                  o_play_valid,
    input uno_pkg::play_result_t o_play,
    input logic                  i_play_ready
);
    // result must hold until the consumer takes it
    play_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_play_valid && !i_play_ready) |=> (o_play_valid && $stable(o_play)))
        else $error("o_play changed while stalled");

    ready_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_card_ready |-> o_draw_req)
        else $error("o_card_ready without o_draw_req");

    no_turn_during_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_play_valid |-> !o_turn_ready)
        else $error("o_turn_ready high while a result is pending");

endmodule

bind uno_player uno_player_checker checker_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .o_turn_ready (o_turn_ready),
    .o_draw_req   (o_draw_req),
    .o_card_ready (o_card_ready),
    .o_play_valid (o_play_valid),
    .o_play       (o_play),
    .i_play_ready (i_play_ready)
);

// ==== bench/uno_player_tb.sv ====
`timescale 1ns/1ps
`include "uno_consts.svh"

module uno_player_tb;
    import uno_pkg::*;

    logic i_clk = 1'b0, i_rst_n, i_deal, i_turn_valid, i_card_valid, i_play_ready;
    logic o_turn_ready, o_draw_req, o_card_ready, o_play_valid;
    card_t i_top_card, i_card;
    play_result_t o_play;

    card_t deck_q[$];
    card_t model_card[`HAND_SLOTS];
    bit    model_used[`HAND_SLOTS];
    logic [31:0] rng = 32'h286e;
    bit    use_gaps;
    int    xfer_count, errors, tests, failed_tests;

    uno_player dut_i (.*);

    always #10 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic card_t mk(input int c, input int v);
        return {color_t'(c), value_t'(v)};
    endfunction

    // deck model, one idle cycle after each transfer
    always @(posedge i_clk) begin
        if (i_card_valid && o_card_ready) begin
            for (int i = 0; i < `HAND_SLOTS; i++) begin
                if (!model_used[i]) begin
                    model_used[i] = 1'b1;
                    model_card[i] = deck_q[0];
                    break;
                end
            end
            void'(deck_q.pop_front());
            xfer_count++;
            i_card_valid <= 1'b0;
        end else if (!i_card_valid && o_draw_req && deck_q.size() > 0) begin
            rng = xorshift(rng);
            if (!use_gaps || rng[1:0] == 2'b00) begin
                i_card_valid <= 1'b1;
                i_card       <= deck_q[0];
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic compare_hand();
        for (int i = 0; i < `HAND_SLOTS; i++) begin
            check($sformatf("slot_used[%0d]", i), dut_i.slot_used[i], model_used[i]);
            if (model_used[i])
                check($sformatf("hand[%0d]", i), dut_i.hand[i], model_card[i]);
        end
    endtask

    // colour, then value, then wild; lowest slot in each tier
    task automatic expect_pick(input card_t top, output bit found, output int idx);
        found = 1'b0;
        for (int tier = 0; tier < 3 && !found; tier++) begin
            for (int i = 0; i < `HAND_SLOTS && !found; i++) begin
                bit wild;
                wild = model_card[i].value == `WILD_VALUE;
                if (model_used[i] && ((tier == 0 && !wild && model_card[i].color == top.color) ||
                    (tier == 1 && !wild && model_card[i].value == top.value) ||
                    (tier == 2 && wild))) begin
                    found = 1'b1;
                    idx   = i;
                end
            end
        end
    endtask

    // holds the turn on the port until the DUT takes it
    task automatic send_turn(input card_t top);
        int n;
        i_turn_valid <= 1'b1;
        i_top_card   <= top;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
            if (n > 500) timed_out("o_turn_ready");
        end while (!o_turn_ready);
        i_turn_valid <= 1'b0;
    endtask

    task automatic deal(input bit gaps);
        int n;
        use_gaps   = gaps;
        xfer_count = 0;
        @(posedge i_clk);
        i_deal <= 1'b1;
        @(posedge i_clk);
        i_deal <= 1'b0;
        n = 0;
        while (xfer_count < `DEAL_COUNT || !o_turn_ready) begin
            @(posedge i_clk);
            n++;
            if (n > 1000) timed_out("the deal to finish");
        end
        repeat (3) @(posedge i_clk);
        check("xfer_count", xfer_count, `DEAL_COUNT);
        check("o_draw_req", o_draw_req, 1'b0);
        compare_hand();
    endtask

    // one turn; hold delays i_play_ready while o_play must stay put
    task automatic play_turn(input card_t top, input int hold, input bit check_lat);
        play_result_t exp, first;
        bit found;
        int idx, n;
        expect_pick(top, found, idx);
        exp = found ? {1'b1, model_card[idx]} : '0;
        xfer_count = 0;
        send_turn(top);
        n = 0;
        while (!o_play_valid) begin
            @(posedge i_clk);
            n++;
            if (n > 500) timed_out("o_play_valid");
        end
        // o_play_valid seen pre-edge at edge n, so it rose at edge n-1
        if (check_lat) check("play latency", n - 1, 2);
        first = o_play;
        check("o_play", o_play, exp);
        repeat (hold) begin
            @(posedge i_clk);
            check("o_play_valid", o_play_valid, 1'b1);
            check("o_play held", o_play, first);
        end
        i_play_ready <= 1'b1;
        @(posedge i_clk);
        i_play_ready <= 1'b0;
        if (found) model_used[idx] = 1'b0;
        check("xfer_count", xfer_count, found ? 0 : 1); // a played turn draws nothing
        repeat (2) @(posedge i_clk);
        compare_hand();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) failed_tests++;
        $display("%-14s %s", name, (errors == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        int e;
        i_rst_n = 1'b0;
        i_deal = 1'b0;
        i_turn_valid = 1'b0;
        i_top_card = '0;
        i_card_valid = 1'b0;
        i_card = '0;
        i_play_ready = 1'b0;
        use_gaps = 1'b0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        e = errors;
        check("o_draw_req", o_draw_req, 1'b0);
        check("o_card_ready", o_card_ready, 1'b0);
        check("o_play_valid", o_play_valid, 1'b0);
        check("o_turn_ready", o_turn_ready, 1'b1);
        // the last card stays in the deck unless the player overdraws
        deck_q = '{mk(0, 5), mk(1, 3), mk(2, 7), mk(3, 13), mk(0, 9), mk(1, 5), mk(2, 2),
                   mk(3, 1)};
        deal(1'b0);
        finish_test("deal", e);
        e = errors;
        play_turn(mk(0, 1), 0, 1'b1);
        finish_test("colour match", e);
        e = errors;
        play_turn(mk(3, 5), 0, 1'b1);
        finish_test("value match", e);
        e = errors;
        deck_q = '{mk(0, 4), mk(2, 11)};
        play_turn(mk(3, 8), 0, 1'b0);
        play_turn(mk(3, 4), 0, 1'b0);
        check("deck left", deck_q.size(), 1);
        finish_test("wild and draw", e);
        e = errors;
        play_turn(mk(1, 0), 6, 1'b0);
        deck_q = '{mk(1, 1), mk(3, 6), mk(0, 13), mk(2, 10), mk(1, 12), mk(0, 0), mk(3, 3),
                   mk(2, 4)};
        deal(1'b1);
        finish_test("back-pressure", e);
        $display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/uno_pkg.sv
hdl/card_intake.sv
hdl/hand_store.sv
hdl/play_selector.sv
hdl/uno_player.sv
bench/uno_player_checker.sv
bench/uno_player_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module uno_player_tb -f compile.f -o sim_uno_player

./obj_dir/sim_uno_player > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
